// File: alu.sv
`timescale 1ns/1ps

module alu import rvIsaPkg::*, cpuCtrlPkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOpT           op,
    output logic [XLEN-1:0] result,
    output logic            zero,
    output logic            lessThan,
    output logic            lessThanU
);

    logic [$clog2(XLEN)-1:0] shamt;

    assign shamt     = b[$clog2(XLEN)-1:0];
    assign lessThan  = $signed(a) < $signed(b);
    assign lessThanU = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, lessThan};
            SLTU:    result = {{(XLEN-1){1'b0}}, lessThanU};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            OR:      result = a | b;
            AND:     result = a & b;
            PASSB:   result = b;
            default: result = '0;
        endcase
    end

    // equality when op is SUB
    assign zero = (result == '0);

endmodule

// File: build.f
+incdir+.
rvIsaPkg.sv
cpuCtrlPkg.sv
controller.sv
alu.sv
immDecoder.sv
registerFile.sv
loadStoreUnit.sv
cpu.sv
tbClock.sv
cpuTb.sv

// File: controller.sv
`timescale 1ns/1ps

module controller import rvIsaPkg::*, cpuCtrlPkg::*; (
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic        zero,
    input  logic        lessThan,
    input  logic        lessThanU,
    output aluOpT       aluOp,
    output srcASelT     srcASel,
    output srcBSelT     srcBSel,
    output wbSelT       wbSel,
    output memWidthT    memWidth,
    output logic        memWr,
    output logic        regWr,
    output logic        takeJump,
    output logic        jumpFromAlu
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       altFunct;
    logic       branchTaken;

    assign opcode   = opcodeT'(instruction[OPCODE_LSB +: 7]);
    assign funct3   = instruction[FUNCT3_LSB +: 3];
    assign altFunct = instruction[FUNCT7_LSB + 5];
    assign memWidth = memWidthT'(funct3);

    // SUB only exists in register form, SRA in both
    function automatic aluOpT decodeAluOp(input logic [2:0] f3, input logic alt,
                                          input logic isReg);
        case (f3)
            3'b000:  decodeAluOp = (isReg && alt) ? SUB : ADD;
            3'b001:  decodeAluOp = SLL;
            3'b010:  decodeAluOp = SLT;
            3'b011:  decodeAluOp = SLTU;
            3'b100:  decodeAluOp = XOR;
            3'b101:  decodeAluOp = alt ? SRA : SRL;
            3'b110:  decodeAluOp = OR;
            default: decodeAluOp = AND;
        endcase
    endfunction

    // flags come from rs1 - rs2
    always_comb begin
        case (branchFunctT'(funct3))
            BEQ:     branchTaken = zero;
            BNE:     branchTaken = !zero;
            BLT:     branchTaken = lessThan;
            BGE:     branchTaken = !lessThan;
            BLTU:    branchTaken = lessThanU;
            BGEU:    branchTaken = !lessThanU;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        aluOp       = ADD;
        srcASel     = A_REG;
        srcBSel     = B_IMM;
        wbSel       = WB_ALU;
        memWr       = 1'b0;
        regWr       = 1'b0;
        takeJump    = 1'b0;
        jumpFromAlu = 1'b0;
        case (opcode)
            OP: begin
                srcBSel = B_REG;
                aluOp   = decodeAluOp(funct3, altFunct, 1'b1);
                regWr   = 1'b1;
            end
            OP_IMM: begin
                aluOp = decodeAluOp(funct3, altFunct, 1'b0);
                regWr = 1'b1;
            end
            LUI: begin
                aluOp = PASSB;
                regWr = 1'b1;
            end
            AUIPC: begin
                srcASel = A_PC;
                regWr   = 1'b1;
            end
            JAL: begin
                wbSel    = WB_PC4;
                regWr    = 1'b1;
                takeJump = 1'b1;
            end
            JALR: begin
                wbSel       = WB_PC4;
                regWr       = 1'b1;
                takeJump    = 1'b1;
                jumpFromAlu = 1'b1;
            end
            BRANCH: begin
                srcBSel  = B_REG;
                aluOp    = SUB;
                takeJump = branchTaken;
            end
            LOAD: begin
                wbSel = WB_MEM;
                regWr = memWidth inside {BYTE, HALF, WORD, BYTEU, HALFU};
            end
            STORE: begin
                memWr = memWidth inside {BYTE, HALF, WORD};
            end
            // fence, system and unknown opcodes fall through as no-ops
            default: ;
        endcase
        if (reset) begin
            memWr = 1'b0;
            regWr = 1'b0;
        end
    end

    always_comb begin
        assert (!(memWr && regWr))
            else $error("controller: memWr and regWr both high");
    end

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu import rvIsaPkg::*, cpuCtrlPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     instruction,
    input  logic [XLEN-1:0] memReadData,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] memAddr,
    output logic [XLEN-1:0] memWriteData,
    output logic [3:0]      wrMask,
    output logic            memWr
);

    aluOpT    aluOp;
    srcASelT  srcASel;
    srcBSelT  srcBSel;
    wbSelT    wbSel;
    memWidthT memWidth;
    logic     regWr;
    logic     takeJump;
    logic     jumpFromAlu;
    logic     zero;
    logic     lessThan;
    logic     lessThanU;

    logic [XLEN-1:0] rs1Data, rs2Data, imm;
    logic [XLEN-1:0] aluA, aluB, aluResult;
    logic [XLEN-1:0] loadData, rdData;
    logic [XLEN-1:0] pcPlus4, jumpTarget, nextPc;

    controller ctrl (
        .reset(reset),
        .instruction(instruction),
        .zero(zero),
        .lessThan(lessThan),
        .lessThanU(lessThanU),
        .aluOp(aluOp),
        .srcASel(srcASel),
        .srcBSel(srcBSel),
        .wbSel(wbSel),
        .memWidth(memWidth),
        .memWr(memWr),
        .regWr(regWr),
        .takeJump(takeJump),
        .jumpFromAlu(jumpFromAlu)
    );

    immDecoder immDec (
        .instruction(instruction),
        .imm(imm)
    );

    registerFile regFile (
        .clk(clk),
        .rs1Addr(instruction[RS1_LSB +: REG_ADDR_W]),
        .rs2Addr(instruction[RS2_LSB +: REG_ADDR_W]),
        .rdAddr(instruction[RD_LSB +: REG_ADDR_W]),
        .rdData(rdData),
        .regWr(regWr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    assign aluA = (srcASel == A_PC) ? pc : rs1Data;
    assign aluB = (srcBSel == B_IMM) ? imm : rs2Data;

    alu aluUnit (
        .a(aluA),
        .b(aluB),
        .op(aluOp),
        .result(aluResult),
        .zero(zero),
        .lessThan(lessThan),
        .lessThanU(lessThanU)
    );

    assign memAddr = aluResult;

    loadStoreUnit lsu (
        .addrLow(aluResult[1:0]),
        .memWidth(memWidth),
        .memWr(memWr),
        .storeData(rs2Data),
        .memReadData(memReadData),
        .memWriteData(memWriteData),
        .wrMask(wrMask),
        .loadData(loadData)
    );

    always_comb begin
        case (wbSel)
            WB_MEM:  rdData = loadData;
            WB_PC4:  rdData = pcPlus4;
            default: rdData = aluResult;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign pcPlus4    = pc + PC_STEP;
    assign jumpTarget = jumpFromAlu ? {aluResult[XLEN-1:1], 1'b0} : pc + imm;
    assign nextPc     = takeJump ? jumpTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: cpuCtrlPkg.sv
package cpuCtrlPkg;

    // first fetch address and sequential step
    localparam int unsigned RESET_PC = 0;
    localparam int unsigned PC_STEP = 4;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB
    } aluOpT;

    // alu operand a
    typedef enum logic {
        A_REG,
        A_PC
    } srcASelT;

    // alu operand b
    typedef enum logic {
        B_REG,
        B_IMM
    } srcBSelT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wbSelT;

endpackage

// File: tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]     lcgState = 32'd65330;
logic [31:0]     imem [0:255];
logic [XLEN-1:0] mRegs [0:31];
logic [XLEN-1:0] mMem [0:63];
logic [XLEN-1:0] mPc;
logic            expStore;
logic [XLEN-1:0] expAddr;
logic [XLEN-1:0] expData;
logic [3:0]      expMask;

function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
endfunction

// upper bits of the lcg are the better ones
function automatic int unsigned randBelow(int unsigned n);
    return (nextRand() >> 16) % n;
endfunction

function automatic logic [31:0] encodeStore(logic [11:0] off, logic [4:0] rs2, logic [2:0] f3);
    return {off[11:5], rs2, 5'd0, f3, off[4:0], STORE};
endfunction

function automatic logic [31:0] encodeBranch(logic [12:0] imm, logic [4:0] rs1,
                                             logic [4:0] rs2, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic logic [31:0] encodeJal(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

// x0-relative offset inside the 256-byte data memory, aligned to the width
function automatic logic [11:0] alignedOffset(logic [2:0] f3);
    logic [11:0] off;
    off = 12'(randBelow(256));
    if (f3[1:0] == 2'b10) begin
        off[1:0] = 2'b00;
    end
    if (f3[1:0] == 2'b01) begin
        off[0] = 1'b0;
    end
    return off;
endfunction

task automatic genProgram();
    int         i;
    int         k;
    int         pick;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] off;
    // x1..x7 get known values first
    for (i = 0; i < 7; i++) begin
        imem[i] = {12'(nextRand()), 5'd0, 3'b000, 5'(i + 1), OP_IMM};
    end
    while (i < 255) begin
        rd  = 5'(randBelow(8));
        rs1 = 5'(randBelow(8));
        rs2 = 5'(randBelow(8));
        // forward targets only, never past the last word
        k = 1 + int'(randBelow(8));
        if (i + k > 255) begin
            k = 255 - i;
        end
        pick = int'(randBelow(10));
        case (pick)
            0: begin
                f3 = 3'(randBelow(8));
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && randBelow(2) == 1) ? 7'h20 : 7'h00;
                imem[i] = {f7, rs2, rs1, f3, rd, OP};
            end
            1: begin
                f3  = 3'(randBelow(8));
                off = 12'(nextRand());
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    off[11:5] = (f3 == 3'b101 && randBelow(2) == 1) ? 7'h20 : 7'h00;
                end
                imem[i] = {off, rs1, f3, rd, OP_IMM};
            end
            2: imem[i] = {20'(nextRand()), rd, LUI};
            3: imem[i] = {20'(nextRand()), rd, AUIPC};
            4: imem[i] = encodeJal(21'(4 * k), rd);
            // odd immediates exercise the cleared bit 0
            5: imem[i] = {12'(4 * (i + k) + int'(randBelow(2))), 5'd0, 3'b000, rd, JALR};
            6: begin
                pick = int'(randBelow(6));
                f3   = 3'(pick < 2 ? pick : pick + 2);
                imem[i] = encodeBranch(13'(4 * k), rs1, rs2, f3);
            end
            7: begin
                pick = int'(randBelow(5));
                f3   = 3'(pick < 3 ? pick : pick + 1);
                imem[i] = {alignedOffset(f3), 5'd0, f3, rd, LOAD};
                // store the loaded register right away
                if (i < 254) begin
                    i++;
                    f3 = 3'(randBelow(3));
                    imem[i] = encodeStore(alignedOffset(f3), rd, f3);
                end
            end
            default: begin
                f3 = 3'(randBelow(3));
                imem[i] = encodeStore(alignedOffset(f3), rs2, f3);
            end
        endcase
        i++;
    end
    imem[255] = encodeJal(21'(-1020), 5'd0);
endtask

function automatic logic [XLEN-1:0] aluRef(logic [2:0] f3, logic alt,
                                           logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = {31'd0, $signed(a) < $signed(b)};
        3'b011:  r = {31'd0, a < b};
        3'b100:  r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branchTakenRef(logic [2:0] f3, logic [XLEN-1:0] a,
                                        logic [XLEN-1:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [XLEN-1:0] laneBits(logic [3:0] mask);
    return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
endfunction

function automatic logic [XLEN-1:0] mergeLanes(logic [XLEN-1:0] old, logic [XLEN-1:0] data,
                                               logic [3:0] mask);
    return (old & ~laneBits(mask)) | (data & laneBits(mask));
endfunction

// one instruction of the reference ISA, sets the expected store
function automatic void modelStep(logic [31:0] ins);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] iImm;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] nextPc;
    logic [2:0]      f3;
    logic            wr;
    a        = mRegs[ins[19:15]];
    b        = mRegs[ins[24:20]];
    f3       = ins[14:12];
    iImm     = {{20{ins[31]}}, ins[31:20]};
    nextPc   = mPc + 32'd4;
    value    = '0;
    wr       = 1'b1;
    expStore = 1'b0;
    case (opcodeT'(ins[6:0]))
        OP:     value = aluRef(f3, ins[30], a, b);
        OP_IMM: value = aluRef(f3, f3 == 3'b101 && ins[30], a, iImm);
        LUI:    value = {ins[31:12], 12'b0};
        AUIPC:  value = mPc + {ins[31:12], 12'b0};
        JAL: begin
            value  = mPc + 32'd4;
            nextPc = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        JALR: begin
            value  = mPc + 32'd4;
            nextPc = (a + iImm) & ~32'd1;
        end
        BRANCH: begin
            wr = 1'b0;
            if (branchTakenRef(f3, a, b)) begin
                nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        LOAD: begin
            addr = a + iImm;
            word = mMem[addr[7:2]] >> (8 * addr[1:0]);
            case (f3)
                3'b000:  value = {{24{word[7]}}, word[7:0]};
                3'b001:  value = {{16{word[15]}}, word[15:0]};
                3'b100:  value = {24'd0, word[7:0]};
                3'b101:  value = {16'd0, word[15:0]};
                default: value = word;
            endcase
        end
        STORE: begin
            wr       = 1'b0;
            addr     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            expStore = 1'b1;
            expAddr  = addr;
            expMask  = (f3 == 3'b000 ? 4'b0001 : f3 == 3'b001 ? 4'b0011 : 4'b1111) << addr[1:0];
            expData  = b << (8 * addr[1:0]);
            mMem[addr[7:2]] = mergeLanes(mMem[addr[7:2]], expData, expMask);
        end
        default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        mRegs[ins[11:7]] = value;
    end
    mPc = nextPc;
endfunction

`endif

// File: cpuTb.sv
`timescale 1ns/1ps

module cpuTb import rvIsaPkg::*; ();

    localparam int NUM_INSTR    = 3000;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int SETTLE_DELAY = 5;
    localparam int EDGE_TIMEOUT = 200;
    localparam int MAX_ERRORS   = 20;
    // sw x1, 0(x0), must stay silent under reset
    localparam logic [31:0] STORE_PROBE = 32'h0010_2023;

    logic            clk;
    logic            reset;
    logic [31:0]     instruction;
    logic [XLEN-1:0] memReadData;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] memAddr;
    logic [XLEN-1:0] memWriteData;
    logic [3:0]      wrMask;
    logic            memWr;

    // data memory as the dut sees it
    logic [XLEN-1:0] dmem [0:63];
    logic            pendWr;
    logic [XLEN-1:0] pendAddr;
    logic [XLEN-1:0] pendData;
    logic [3:0]      pendMask;
    int              errors;
    int              timeouts;

    `include "tbModel.svh"

    tbClock clkGen (.clk(clk));

    cpu dut (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .memReadData(memReadData),
        .pc(pc),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .wrMask(wrMask),
        .memWr(memWr)
    );

    task automatic checkWord(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkMask(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic nextEdge();
        int waited;
        waited = 0;
        while (clk !== 1'b0 && waited < EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        while (clk !== 1'b1 && waited < EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        if (waited >= EDGE_TIMEOUT) begin
            timeouts++;
            $display("no rising clock edge within %0d ns", EDGE_TIMEOUT);
        end
    endtask

    // both copies of data memory start from the same lcg values
    task automatic initMemories();
        for (int w = 0; w < 64; w++) begin
            dmem[w] = nextRand();
            mMem[w] = dmem[w];
        end
        for (int r = 0; r < 32; r++) begin
            mRegs[r] = '0;
        end
        mPc = '0;
    endtask

    initial begin
        int n;
        reset       = 1'b1;
        instruction = STORE_PROBE;
        memReadData = '0;
        pendWr      = 1'b0;
        errors      = 0;
        timeouts    = 0;
        genProgram();
        initMemories();
        // last reset edge opens the main loop
        for (n = 0; n < RESET_CYCLES - 1 && timeouts == 0; n++) begin
            nextEdge();
            #DRIVE_DELAY;
            instruction = STORE_PROBE;
            #SETTLE_DELAY;
            checkBit("memWr", memWr, 1'b0);
            checkMask("wrMask", wrMask, 4'b0000);
        end
        for (n = 0; n < NUM_INSTR && timeouts == 0 && errors < MAX_ERRORS; n++) begin
            nextEdge();
            if (pendWr) begin
                dmem[pendAddr[7:2]] = mergeLanes(dmem[pendAddr[7:2]], pendData, pendMask);
            end
            #DRIVE_DELAY;
            reset       = 1'b0;
            instruction = imem[pc[9:2]];
            #1;
            memReadData = dmem[memAddr[7:2]];
            #SETTLE_DELAY;
            checkWord("pc", pc, mPc);
            modelStep(imem[mPc[9:2]]);
            checkBit("memWr", memWr, expStore);
            if (expStore) begin
                checkWord("memAddr", memAddr, expAddr);
                checkMask("wrMask", wrMask, expMask);
                checkWord("memWriteData", memWriteData & laneBits(expMask),
                          expData & laneBits(expMask));
            end else begin
                checkMask("wrMask", wrMask, 4'b0000);
            end
            pendWr   = memWr;
            pendAddr = memAddr;
            pendData = memWriteData;
            pendMask = wrMask;
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: immDecoder.sv
`timescale 1ns/1ps

module immDecoder import rvIsaPkg::*; (
    input  logic [31:0]     instruction,
    output logic [XLEN-1:0] imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (opcodeT'(instruction[OPCODE_LSB +: 7]))
            STORE: begin
                imm = {{(XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            end
            BRANCH: begin
                imm = {{(XLEN-12){sign}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            LUI, AUIPC: begin
                imm = {instruction[31:12], 12'b0};
            end
            JAL: begin
                imm = {{(XLEN-20){sign}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            // I format for loads, op-imm, jalr and the rest
            default: begin
                imm = {{(XLEN-12){sign}}, instruction[31:20]};
            end
        endcase
    end

endmodule

// File: loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit import rvIsaPkg::*; (
    input  logic [1:0]      addrLow,
    input  memWidthT        memWidth,
    input  logic            memWr,
    input  logic [XLEN-1:0] storeData,
    input  logic [XLEN-1:0] memReadData,
    output logic [XLEN-1:0] memWriteData,
    output logic [3:0]      wrMask,
    output logic [XLEN-1:0] loadData
);

    logic [4:0]      laneShift;
    logic [3:0]      baseMask;
    logic [XLEN-1:0] readShifted;

    assign laneShift    = {addrLow, 3'b000};
    assign memWriteData = storeData << laneShift;

    always_comb begin
        case (memWidth)
            BYTE, BYTEU: baseMask = 4'b0001;
            HALF, HALFU: baseMask = 4'b0011;
            default:     baseMask = 4'b1111;
        endcase
    end

    assign wrMask = memWr ? (baseMask << addrLow) : 4'b0000;

    // addressed lanes down to bit 0
    assign readShifted = memReadData >> laneShift;

    always_comb begin
        case (memWidth)
            BYTE:    loadData = {{(XLEN-8){readShifted[7]}}, readShifted[7:0]};
            HALF:    loadData = {{(XLEN-16){readShifted[15]}}, readShifted[15:0]};
            BYTEU:   loadData = {{(XLEN-8){1'b0}}, readShifted[7:0]};
            HALFU:   loadData = {{(XLEN-16){1'b0}}, readShifted[15:0]};
            default: loadData = memReadData;
        endcase
    end

    always_comb begin
        assert (!(memWr && memWidth == HALF && addrLow == 2'b11))
            else $error("loadStoreUnit: halfword store crosses word boundary");
    end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile import rvIsaPkg::*; (
    input  logic            clk,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    input  logic [4:0]      rdAddr,
    input  logic [XLEN-1:0] rdData,
    input  logic            regWr,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data
);

    logic [XLEN-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (regWr && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 never holds a written value
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    assert property (@(posedge clk) (rs1Addr == 5'd0) |-> (rs1Data == '0))
        else $error("registerFile: x0 read nonzero");

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f build.f -o cpuTbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpuTbSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN = 32;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int FUNCT7_LSB = 25;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } opcodeT;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchFunctT;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        BYTE  = 3'b000,
        HALF  = 3'b001,
        WORD  = 3'b010,
        BYTEU = 3'b100,
        HALFU = 3'b101
    } memWidthT;

endpackage

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule
